// ==== design/cnn_pkg.sv ====
package cnn_pkg;

  // ------------------------------
  // word and accumulator widths
  // ------------------------------
  localparam int DATA_W = 32;
  localparam int ACC_W  = 64;

  // sums are rounded by adding SCALE/2 and dividing by this fixed-point scale
  localparam int SCALE = 128;

  // width of the write and read addresses
  localparam int ADDR_W = 16;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // write port select codes where any unused code is dropped
  typedef enum logic [2:0] {
    SEL_IMG     = 3'd0,
    SEL_CONV_K  = 3'd1,
    SEL_CONV_B  = 3'd2,
    SEL_DENSE_K = 3'd3,
    SEL_DENSE_B = 3'd4
  } mem_sel_t;

  // top level sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CONV,
    ST_POOL,
    ST_DENSE
  } infer_state_t;

endpackage

// ==== design/cnn_top.sv ====
`timescale 1ns/1ps

module cnn_top #(
  parameter int IMG_H   = 8,
  parameter int IMG_W   = 8,
  parameter int CH_IN   = 2,
  parameter int CONV_CH = 4,
  parameter int CLASSES = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wr_en,
  input  cnn_pkg::mem_sel_t                  wr_sel,
  input  logic [cnn_pkg::ADDR_W-1:0]         wr_addr,
  input  cnn_pkg::data_t                     wr_data,
  input  logic                               start,
  output logic                               done,
  output logic [$clog2(CLASSES)-1:0]         pred_index,
  output logic [CLASSES*cnn_pkg::DATA_W-1:0] logits
);

  // ------------------------------
  // inter-stage wiring
  // ------------------------------
  logic conv_start, pool_start, dense_start;
  logic conv_done, pool_done, dense_done;

  logic [cnn_pkg::ADDR_W-1:0] img_addr, conv_k_addr, conv_b_addr;
  logic [cnn_pkg::ADDR_W-1:0] dense_k_addr, dense_b_addr;
  logic [cnn_pkg::ADDR_W-1:0] fm_addr, avg_addr;

  cnn_pkg::data_t img_data, conv_k_data, conv_b_data;
  cnn_pkg::data_t dense_k_data, dense_b_data;
  cnn_pkg::data_t fm_data, avg_data;

  weight_store #(
    .IMG_H(IMG_H), .IMG_W(IMG_W), .CH_IN(CH_IN), .CONV_CH(CONV_CH), .CLASSES(CLASSES)
  ) u_store (
    .clk(clk), .rst_n(rst_n),
    .wr_en(wr_en), .wr_sel(wr_sel), .wr_addr(wr_addr), .wr_data(wr_data),
    .img_addr(img_addr), .conv_k_addr(conv_k_addr), .conv_b_addr(conv_b_addr),
    .dense_k_addr(dense_k_addr), .dense_b_addr(dense_b_addr),
    .img_data(img_data), .conv_k_data(conv_k_data), .conv_b_data(conv_b_data),
    .dense_k_data(dense_k_data), .dense_b_data(dense_b_data)
  );

  conv_stage #(
    .IMG_H(IMG_H), .IMG_W(IMG_W), .CH_IN(CH_IN), .CONV_CH(CONV_CH)
  ) u_conv (
    .clk(clk), .rst_n(rst_n), .start(conv_start),
    .img_data(img_data), .conv_k_data(conv_k_data), .conv_b_data(conv_b_data),
    .fm_addr(fm_addr), .done(conv_done),
    .img_addr(img_addr), .conv_k_addr(conv_k_addr), .conv_b_addr(conv_b_addr),
    .fm_data(fm_data)
  );

  pool_avg_stage #(
    .IMG_H(IMG_H), .IMG_W(IMG_W), .CONV_CH(CONV_CH)
  ) u_pool (
    .clk(clk), .rst_n(rst_n), .start(pool_start),
    .fm_data(fm_data), .avg_addr(avg_addr),
    .done(pool_done), .fm_addr(fm_addr), .avg_data(avg_data)
  );

  dense_stage #(
    .CONV_CH(CONV_CH), .CLASSES(CLASSES)
  ) u_dense (
    .clk(clk), .rst_n(rst_n), .start(dense_start),
    .avg_data(avg_data), .dense_k_data(dense_k_data), .dense_b_data(dense_b_data),
    .done(dense_done), .avg_addr(avg_addr),
    .dense_k_addr(dense_k_addr), .dense_b_addr(dense_b_addr),
    .logits(logits), .pred_index(pred_index)
  );

  infer_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start),
    .conv_done(conv_done), .pool_done(pool_done), .dense_done(dense_done),
    .conv_start(conv_start), .pool_start(pool_start), .dense_start(dense_start),
    .done(done)
  );

endmodule

// ==== design/conv_stage.sv ====
`timescale 1ns/1ps

module conv_stage #(
  parameter int IMG_H   = 8,
  parameter int IMG_W   = 8,
  parameter int CH_IN   = 2,
  parameter int CONV_CH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  cnn_pkg::data_t             img_data,
  input  cnn_pkg::data_t             conv_k_data,
  input  cnn_pkg::data_t             conv_b_data,
  input  logic [cnn_pkg::ADDR_W-1:0] fm_addr,
  output logic                       done,
  output logic [cnn_pkg::ADDR_W-1:0] img_addr,
  output logic [cnn_pkg::ADDR_W-1:0] conv_k_addr,
  output logic [cnn_pkg::ADDR_W-1:0] conv_b_addr,
  output cnn_pkg::data_t             fm_data
);

  localparam int AW    = cnn_pkg::ADDR_W;
  localparam int FM_SZ = IMG_H * IMG_W * CONV_CH;
  localparam int FM_AW = $clog2(FM_SZ);

  typedef enum logic [1:0] {S_IDLE, S_MAC, S_WRITE} conv_state_t;

  conv_state_t     state;
  logic [AW-1:0]   row, col, oc, ic;
  logic [1:0]      kr, kc;
  cnn_pkg::acc_t   acc;
  cnn_pkg::acc_t   prod;
  cnn_pkg::data_t  pre_act;
  cnn_pkg::data_t  relu;
  logic [FM_AW-1:0] fm_wr_addr;
  logic            tap_ok;
  cnn_pkg::data_t  fm_mem [FM_SZ];

  // ------------------------------
  // tap addressing and arithmetic
  // ------------------------------
  always_comb begin
    int tr;
    int tc;
    tr = int'(row) + int'(kr) - 1;
    tc = int'(col) + int'(kc) - 1;
    // padding taps read nothing and add zero
    tap_ok = (tr >= 0) && (tr < IMG_H) && (tc >= 0) && (tc < IMG_W);
    img_addr = tap_ok ? AW'((tr * IMG_W + tc) * CH_IN + int'(ic)) : '0;
    conv_k_addr = AW'(((int'(kr) * 3 + int'(kc)) * CH_IN + int'(ic)) * CONV_CH + int'(oc));
    prod = tap_ok ? cnn_pkg::acc_t'(img_data) * cnn_pkg::acc_t'(conv_k_data) : '0;
    pre_act = cnn_pkg::data_t'((acc + cnn_pkg::acc_t'(cnn_pkg::SCALE / 2)) /
                               cnn_pkg::acc_t'(cnn_pkg::SCALE)) + conv_b_data;
    relu = pre_act[cnn_pkg::DATA_W-1] ? '0 : pre_act;
    fm_wr_addr = FM_AW'((int'(row) * IMG_W + int'(col)) * CONV_CH + int'(oc));
  end

  assign conv_b_addr = oc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      done  <= 1'b0;
      row   <= '0;
      col   <= '0;
      oc    <= '0;
      ic    <= '0;
      kr    <= '0;
      kc    <= '0;
      acc   <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: if (start) state <= S_MAC;
        S_MAC: begin
          acc <= acc + prod;
          if (ic != AW'(CH_IN - 1)) begin
            ic <= ic + 1'b1;
          end else begin
            ic <= '0;
            if (kc != 2'd2) begin
              kc <= kc + 2'd1;
            end else begin
              kc <= '0;
              if (kr != 2'd2) begin
                kr <= kr + 2'd1;
              end else begin
                kr    <= '0;
                state <= S_WRITE;
              end
            end
          end
        end
        S_WRITE: begin
          acc   <= '0;
          state <= S_MAC;
          // next output channel, then column, then row
          if (oc != AW'(CONV_CH - 1)) begin
            oc <= oc + 1'b1;
          end else begin
            oc <= '0;
            if (col != AW'(IMG_W - 1)) begin
              col <= col + 1'b1;
            end else begin
              col <= '0;
              if (row != AW'(IMG_H - 1)) begin
                row <= row + 1'b1;
              end else begin
                row   <= '0;
                state <= S_IDLE;
                done  <= 1'b1;
              end
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_WRITE) fm_mem[fm_wr_addr] <= relu;
  end

  assign fm_data = fm_mem[fm_addr[FM_AW-1:0]];

endmodule

// ==== design/dense_stage.sv ====
`timescale 1ns/1ps

module dense_stage #(
  parameter int CONV_CH = 4,
  parameter int CLASSES = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start,
  input  cnn_pkg::data_t                    avg_data,
  input  cnn_pkg::data_t                    dense_k_data,
  input  cnn_pkg::data_t                    dense_b_data,
  output logic                              done,
  output logic [cnn_pkg::ADDR_W-1:0]        avg_addr,
  output logic [cnn_pkg::ADDR_W-1:0]        dense_k_addr,
  output logic [cnn_pkg::ADDR_W-1:0]        dense_b_addr,
  output logic [CLASSES*cnn_pkg::DATA_W-1:0] logits,
  output logic [$clog2(CLASSES)-1:0]        pred_index
);

  localparam int AW  = cnn_pkg::ADDR_W;
  localparam int DW  = cnn_pkg::DATA_W;
  localparam int PIW = $clog2(CLASSES);

  typedef enum logic [1:0] {S_IDLE, S_MAC, S_ARG} dense_state_t;

  dense_state_t   state;
  logic [AW-1:0]  cls, idx, k;
  cnn_pkg::acc_t  acc;
  cnn_pkg::acc_t  full;
  cnn_pkg::data_t logit_new;
  cnn_pkg::data_t cur;
  cnn_pkg::data_t best;

  assign avg_addr     = idx;
  assign dense_k_addr = AW'(int'(idx) * CLASSES + int'(cls));
  assign dense_b_addr = cls;

  // last product is folded in so the logit lands on the final mac cycle
  assign full = acc + cnn_pkg::acc_t'(avg_data) * cnn_pkg::acc_t'(dense_k_data);
  assign logit_new = cnn_pkg::data_t'((full + cnn_pkg::acc_t'(cnn_pkg::SCALE / 2)) /
                                       cnn_pkg::acc_t'(cnn_pkg::SCALE)) + dense_b_data;
  assign cur = cnn_pkg::data_t'(logits[int'(k)*DW +: DW]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      done       <= 1'b0;
      cls        <= '0;
      idx        <= '0;
      k          <= '0;
      acc        <= '0;
      best       <= '0;
      logits     <= '0;
      pred_index <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: if (start) state <= S_MAC;
        S_MAC: begin
          if (idx != AW'(CONV_CH - 1)) begin
            acc <= full;
            idx <= idx + 1'b1;
          end else begin
            acc <= '0;
            idx <= '0;
            logits[int'(cls)*DW +: DW] <= logit_new;
            if (cls != AW'(CLASSES - 1)) begin
              cls <= cls + 1'b1;
            end else begin
              cls   <= '0;
              state <= S_ARG;
            end
          end
        end
        S_ARG: begin
          // strict compare keeps the lowest index on a tie
          if (k == '0 || cur > best) begin
            best       <= cur;
            pred_index <= k[PIW-1:0];
          end
          if (k != AW'(CLASSES - 1)) begin
            k <= k + 1'b1;
          end else begin
            k     <= '0;
            state <= S_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== design/infer_ctrl.sv ====
`timescale 1ns/1ps

module infer_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic conv_done,
  input  logic pool_done,
  input  logic dense_done,
  output logic conv_start,
  output logic pool_start,
  output logic dense_start,
  output logic done
);

  cnn_pkg::infer_state_t state;

  // stage kicks last one cycle and a start while busy is dropped
  assign conv_start  = (state == cnn_pkg::ST_IDLE) && start;
  assign pool_start  = (state == cnn_pkg::ST_CONV) && conv_done;
  assign dense_start = (state == cnn_pkg::ST_POOL) && pool_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cnn_pkg::ST_IDLE;
      done  <= 1'b0;
    end else begin
      case (state)
        cnn_pkg::ST_IDLE: begin
          if (start) begin
            done  <= 1'b0;
            state <= cnn_pkg::ST_CONV;
          end
        end
        cnn_pkg::ST_CONV: if (conv_done) state <= cnn_pkg::ST_POOL;
        cnn_pkg::ST_POOL: if (pool_done) state <= cnn_pkg::ST_DENSE;
        cnn_pkg::ST_DENSE: begin
          if (dense_done) begin
            done  <= 1'b1;
            state <= cnn_pkg::ST_IDLE;
          end
        end
        default: state <= cnn_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

// ==== design/pool_avg_stage.sv ====
`timescale 1ns/1ps

module pool_avg_stage #(
  parameter int IMG_H   = 8,
  parameter int IMG_W   = 8,
  parameter int CONV_CH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  cnn_pkg::data_t             fm_data,
  input  logic [cnn_pkg::ADDR_W-1:0] avg_addr,
  output logic                       done,
  output logic [cnn_pkg::ADDR_W-1:0] fm_addr,
  output cnn_pkg::data_t             avg_data
);

  localparam int AW     = cnn_pkg::ADDR_W;
  localparam int PH     = IMG_H / 2;
  localparam int PW     = IMG_W / 2;
  localparam int NPOOL  = PH * PW;
  localparam int AVG_AW = $clog2(CONV_CH);

  typedef enum logic [1:0] {S_IDLE, S_SCAN, S_AVG} pool_state_t;

  pool_state_t    state;
  logic [AW-1:0]  ch, pr, pc;
  logic           dy, dx;
  cnn_pkg::data_t mx;
  cnn_pkg::data_t win_max;
  cnn_pkg::acc_t  sum;
  cnn_pkg::data_t avg;
  cnn_pkg::data_t avg_mem [CONV_CH];

  assign fm_addr = AW'(((2 * int'(pr) + int'(dy)) * IMG_W + 2 * int'(pc) + int'(dx)) *
                       CONV_CH + int'(ch));

  // the first word of each 2x2 window seeds its running max
  assign win_max = (!dy && !dx) ? fm_data : ((fm_data > mx) ? fm_data : mx);

  // signed division truncates toward zero
  assign avg = cnn_pkg::data_t'((sum + cnn_pkg::acc_t'(NPOOL / 2)) / cnn_pkg::acc_t'(NPOOL));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      done  <= 1'b0;
      ch    <= '0;
      pr    <= '0;
      pc    <= '0;
      dy    <= 1'b0;
      dx    <= 1'b0;
      mx    <= '0;
      sum   <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: if (start) state <= S_SCAN;
        S_SCAN: begin
          mx <= win_max;
          dx <= ~dx;
          if (dx) begin
            dy <= ~dy;
            if (dy) begin
              // window complete
              sum <= sum + cnn_pkg::acc_t'(win_max);
              if (pc != AW'(PW - 1)) begin
                pc <= pc + 1'b1;
              end else begin
                pc <= '0;
                if (pr != AW'(PH - 1)) begin
                  pr <= pr + 1'b1;
                end else begin
                  pr    <= '0;
                  state <= S_AVG;
                end
              end
            end
          end
        end
        S_AVG: begin
          sum <= '0;
          if (ch != AW'(CONV_CH - 1)) begin
            ch    <= ch + 1'b1;
            state <= S_SCAN;
          end else begin
            ch    <= '0;
            state <= S_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_AVG) avg_mem[ch[AVG_AW-1:0]] <= avg;
  end

  assign avg_data = avg_mem[avg_addr[AVG_AW-1:0]];

endmodule

// ==== design/weight_store.sv ====
`timescale 1ns/1ps

module weight_store #(
  parameter int IMG_H   = 8,
  parameter int IMG_W   = 8,
  parameter int CH_IN   = 2,
  parameter int CONV_CH = 4,
  parameter int CLASSES = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en,
  input  cnn_pkg::mem_sel_t          wr_sel,
  input  logic [cnn_pkg::ADDR_W-1:0] wr_addr,
  input  cnn_pkg::data_t             wr_data,
  input  logic [cnn_pkg::ADDR_W-1:0] img_addr,
  input  logic [cnn_pkg::ADDR_W-1:0] conv_k_addr,
  input  logic [cnn_pkg::ADDR_W-1:0] conv_b_addr,
  input  logic [cnn_pkg::ADDR_W-1:0] dense_k_addr,
  input  logic [cnn_pkg::ADDR_W-1:0] dense_b_addr,
  output cnn_pkg::data_t             img_data,
  output cnn_pkg::data_t             conv_k_data,
  output cnn_pkg::data_t             conv_b_data,
  output cnn_pkg::data_t             dense_k_data,
  output cnn_pkg::data_t             dense_b_data
);

  localparam int IMG_SZ = IMG_H * IMG_W * CH_IN;
  localparam int CK_SZ  = 9 * CH_IN * CONV_CH;
  localparam int CB_SZ  = CONV_CH;
  localparam int DK_SZ  = CONV_CH * CLASSES;
  localparam int DB_SZ  = CLASSES;

  localparam int IMG_AW = $clog2(IMG_SZ);
  localparam int CK_AW  = $clog2(CK_SZ);
  localparam int CB_AW  = $clog2(CB_SZ);
  localparam int DK_AW  = $clog2(DK_SZ);
  localparam int DB_AW  = $clog2(DB_SZ);

  cnn_pkg::data_t img_mem [IMG_SZ];
  cnn_pkg::data_t ck_mem  [CK_SZ];
  cnn_pkg::data_t cb_mem  [CB_SZ];
  cnn_pkg::data_t dk_mem  [DK_SZ];
  cnn_pkg::data_t db_mem  [DB_SZ];

  // writes are ignored while reset is held
  always_ff @(posedge clk) begin
    if (wr_en && rst_n) begin
      case (wr_sel)
        cnn_pkg::SEL_IMG:
          if (int'(wr_addr) < IMG_SZ) img_mem[wr_addr[IMG_AW-1:0]] <= wr_data;
        cnn_pkg::SEL_CONV_K:
          if (int'(wr_addr) < CK_SZ) ck_mem[wr_addr[CK_AW-1:0]] <= wr_data;
        cnn_pkg::SEL_CONV_B:
          if (int'(wr_addr) < CB_SZ) cb_mem[wr_addr[CB_AW-1:0]] <= wr_data;
        cnn_pkg::SEL_DENSE_K:
          if (int'(wr_addr) < DK_SZ) dk_mem[wr_addr[DK_AW-1:0]] <= wr_data;
        cnn_pkg::SEL_DENSE_B:
          if (int'(wr_addr) < DB_SZ) db_mem[wr_addr[DB_AW-1:0]] <= wr_data;
        default: ;
      endcase
    end
  end

  // one asynchronous read port per consumer
  assign img_data     = img_mem[img_addr[IMG_AW-1:0]];
  assign conv_k_data  = ck_mem[conv_k_addr[CK_AW-1:0]];
  assign conv_b_data  = cb_mem[conv_b_addr[CB_AW-1:0]];
  assign dense_k_data = dk_mem[dense_k_addr[DK_AW-1:0]];
  assign dense_b_data = db_mem[dense_b_addr[DB_AW-1:0]];

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the cnn testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_cnn -o sim_cnn
./obj_dir/sim_cnn | tee sim.log
if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== test/tb_cnn.sv ====
`timescale 1ns/1ps

module tb_cnn;

  localparam int IMG_H   = 8;
  localparam int IMG_W   = 8;
  localparam int CH_IN   = 2;
  localparam int CONV_CH = 4;
  localparam int CLASSES = 4;
  localparam int DW      = cnn_pkg::DATA_W;
  localparam int AW      = cnn_pkg::ADDR_W;
  localparam int SEED    = 32'h61f0c33b;

  localparam int IMG_SZ = IMG_H * IMG_W * CH_IN;
  localparam int CK_SZ  = 9 * CH_IN * CONV_CH;
  localparam int DK_SZ  = CONV_CH * CLASSES;
  localparam int NPOOL  = (IMG_H / 2) * (IMG_W / 2);

  // worst-case cycles of each stage of one inference
  localparam int CONV_CYC  = IMG_H * IMG_W * CONV_CH * (9 * CH_IN + 1);
  localparam int POOL_CYC  = CONV_CH * (IMG_H * IMG_W + 1);
  localparam int DENSE_CYC = CLASSES * CONV_CH + CLASSES;
  localparam int INFER_CYC = CONV_CYC + POOL_CYC + DENSE_CYC + 4;
  localparam int LOAD_CYC  = IMG_SZ + CK_SZ + CONV_CH + DK_SZ + CLASSES + 16;
  localparam int N_RUNS    = 5;
  localparam int WATCHDOG_NS = 6 * N_RUNS * (INFER_CYC + LOAD_CYC) * 20;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       wr_en;
  cnn_pkg::mem_sel_t          wr_sel;
  logic [AW-1:0]              wr_addr;
  cnn_pkg::data_t             wr_data;
  logic                       start;
  logic                       done;
  logic [$clog2(CLASSES)-1:0] pred_index;
  logic [CLASSES*DW-1:0]      logits;

  // testbench copies of everything loaded into the DUT
  int img [IMG_SZ];
  int ck  [CK_SZ];
  int cb  [CONV_CH];
  int dk  [DK_SZ];
  int db  [CLASSES];
  int exp_logit [CLASSES];
  int exp_pred;
  int errors = 0;
  int checks = 0;

  cnn_top #(
    .IMG_H(IMG_H), .IMG_W(IMG_W), .CH_IN(CH_IN), .CONV_CH(CONV_CH), .CLASSES(CLASSES)
  ) u_cnn_top (
    .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_sel(wr_sel), .wr_addr(wr_addr),
    .wr_data(wr_data), .start(start), .done(done), .pred_index(pred_index),
    .logits(logits)
  );

  always #10 clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic report_mismatch(string name, int got, int expv);
    errors++;
    $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, expv);
  endtask

  function automatic int rand_in(int lim);
    return int'($urandom_range(2 * lim, 0)) - lim;
  endfunction

  task automatic write_word(cnn_pkg::mem_sel_t sel, int addr, int data);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_sel  <= sel;
    wr_addr <= AW'(addr);
    wr_data <= data;
  endtask

  task automatic end_writes();
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic load_image();
    for (int i = 0; i < IMG_SZ; i++) write_word(cnn_pkg::SEL_IMG, i, img[i]);
    end_writes();
  endtask

  task automatic load_dense_bias();
    for (int i = 0; i < CLASSES; i++) write_word(cnn_pkg::SEL_DENSE_B, i, db[i]);
    end_writes();
  endtask

  task automatic load_all();
    for (int i = 0; i < CK_SZ; i++) write_word(cnn_pkg::SEL_CONV_K, i, ck[i]);
    for (int i = 0; i < CONV_CH; i++) write_word(cnn_pkg::SEL_CONV_B, i, cb[i]);
    for (int i = 0; i < DK_SZ; i++) write_word(cnn_pkg::SEL_DENSE_K, i, dk[i]);
    load_dense_bias();
    load_image();
  endtask

  task automatic random_image();
    for (int i = 0; i < IMG_SZ; i++) img[i] = rand_in(200);
  endtask

  task automatic random_weights();
    for (int i = 0; i < CK_SZ; i++) ck[i] = rand_in(150);
    for (int i = 0; i < CONV_CH; i++) cb[i] = rand_in(2000);
    for (int i = 0; i < DK_SZ; i++) dk[i] = rand_in(200);
    for (int i = 0; i < CLASSES; i++) db[i] = rand_in(500);
  endtask

  // pulse start, expect done low at once, then wait for it to rise
  task automatic run_inference();
    int cycles;
    cycles = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    checks++;
    if (done !== 1'b0) report_mismatch("done", int'(done), 0);
    while (done !== 1'b1 && cycles < 2 * INFER_CYC) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      errors++;
      $display("done did not rise within %0d cycles of start", 2 * INFER_CYC);
    end
  endtask

  task automatic pick_expected_pred();
    exp_pred = 0;
    for (int c = 1; c < CLASSES; c++) begin
      if (exp_logit[c] > exp_logit[exp_pred]) exp_pred = c;
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  task automatic compute_expected();
    int     fm  [IMG_H*IMG_W*CONV_CH];
    int     avg [CONV_CH];
    longint acc;
    int     pre, m, v, tr, tc;
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        for (int oc = 0; oc < CONV_CH; oc++) begin
          acc = 0;
          for (int kr = 0; kr < 3; kr++) begin
            for (int kc = 0; kc < 3; kc++) begin
              tr = r + kr - 1;
              tc = c + kc - 1;
              // zero padding outside the image
              if (tr < 0 || tr >= IMG_H || tc < 0 || tc >= IMG_W) continue;
              for (int ic = 0; ic < CH_IN; ic++) begin
                acc += longint'(img[(tr * IMG_W + tc) * CH_IN + ic]) *
                       longint'(ck[((kr * 3 + kc) * CH_IN + ic) * CONV_CH + oc]);
              end
            end
          end
          pre = int'((acc + cnn_pkg::SCALE / 2) / cnn_pkg::SCALE) + cb[oc];
          fm[(r * IMG_W + c) * CONV_CH + oc] = (pre < 0) ? 0 : pre;
        end
      end
    end
    for (int ch = 0; ch < CONV_CH; ch++) begin
      acc = 0;
      for (int pr = 0; pr < IMG_H / 2; pr++) begin
        for (int pc = 0; pc < IMG_W / 2; pc++) begin
          m = fm[(2 * pr * IMG_W + 2 * pc) * CONV_CH + ch];
          for (int d = 1; d < 4; d++) begin
            v = fm[((2 * pr + d / 2) * IMG_W + 2 * pc + d % 2) * CONV_CH + ch];
            if (v > m) m = v;
          end
          acc += longint'(m);
        end
      end
      avg[ch] = int'((acc + NPOOL / 2) / NPOOL);
    end
    for (int c = 0; c < CLASSES; c++) begin
      acc = 0;
      for (int i = 0; i < CONV_CH; i++) begin
        acc += longint'(avg[i]) * longint'(dk[i * CLASSES + c]);
      end
      exp_logit[c] = int'((acc + cnn_pkg::SCALE / 2) / cnn_pkg::SCALE) + db[c];
    end
    pick_expected_pred();
  endtask

  task automatic check_results(string tag);
    int got;
    for (int c = 0; c < CLASSES; c++) begin
      got = int'(logits[c * DW +: DW]);
      checks++;
      if (got != exp_logit[c]) begin
        report_mismatch($sformatf("%s logits[%0d]", tag, c), got, exp_logit[c]);
      end
    end
    checks++;
    if (int'(pred_index) != exp_pred) begin
      report_mismatch($sformatf("%s pred_index", tag), int'(pred_index), exp_pred);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_values();
    checks++;
    if (done !== 1'b0) report_mismatch("done", int'(done), 0);
    checks++;
    if (pred_index !== '0) report_mismatch("pred_index", int'(pred_index), 0);
    for (int c = 0; c < CLASSES; c++) begin
      checks++;
      if (logits[c * DW +: DW] !== '0) begin
        report_mismatch($sformatf("logits[%0d]", c), int'(logits[c * DW +: DW]), 0);
      end
    end
  endtask

  // centre tap copies image channel oc % CH_IN and the dense kernel is identity
  task automatic test_hand_case();
    longint sum;
    int     m, v, ic;
    for (int i = 0; i < IMG_SZ; i++) img[i] = int'($urandom_range(1000, 0));
    for (int i = 0; i < CK_SZ; i++) ck[i] = 0;
    for (int oc = 0; oc < CONV_CH; oc++) begin
      cb[oc] = 0;
      ck[(4 * CH_IN + oc % CH_IN) * CONV_CH + oc] = cnn_pkg::SCALE;
    end
    for (int i = 0; i < DK_SZ; i++) dk[i] = (i / CLASSES == i % CLASSES) ? cnn_pkg::SCALE : 0;
    for (int c = 0; c < CLASSES; c++) db[c] = 0;
    load_all();
    run_inference();
    for (int c = 0; c < CLASSES; c++) begin
      ic = c % CH_IN;
      sum = 0;
      for (int pr = 0; pr < IMG_H / 2; pr++) begin
        for (int pc = 0; pc < IMG_W / 2; pc++) begin
          m = 0;
          for (int d = 0; d < 4; d++) begin
            v = img[((2 * pr + d / 2) * IMG_W + 2 * pc + d % 2) * CH_IN + ic];
            if (v > m) m = v;
          end
          sum += longint'(m);
        end
      end
      exp_logit[c] = int'((sum + NPOOL / 2) / NPOOL);
    end
    pick_expected_pred();
    check_results("hand");
  endtask

  task automatic test_random();
    random_image();
    random_weights();
    load_all();
    compute_expected();
    run_inference();
    check_results("random");
  endtask

  task automatic test_bad_writes();
    write_word(cnn_pkg::SEL_IMG, IMG_SZ, rand_in(999));
    write_word(cnn_pkg::SEL_CONV_K, CK_SZ, rand_in(999));
    write_word(cnn_pkg::SEL_CONV_B, CONV_CH, rand_in(999));
    write_word(cnn_pkg::SEL_DENSE_K, DK_SZ, rand_in(999));
    write_word(cnn_pkg::SEL_DENSE_B, CLASSES, rand_in(999));
    write_word(cnn_pkg::SEL_IMG, 65535, rand_in(999));
    for (int code = 5; code < 8; code++) begin
      write_word(cnn_pkg::mem_sel_t'(3'(code)), 0, rand_in(999));
    end
    end_writes();
    run_inference();
    check_results("bad writes");
  endtask

  task automatic test_new_image();
    random_image();
    load_image();
    compute_expected();
    run_inference();
    check_results("new image");
  endtask

  // biases lift classes 1 and 2 to the same top value
  task automatic test_tie_break();
    int top;
    for (int c = 0; c < CLASSES; c++) db[c] = 0;
    compute_expected();
    top = exp_logit[exp_pred] + 1000;
    for (int c = 0; c < CLASSES; c++) begin
      db[c] = top - exp_logit[c] - ((c == 1 || c == 2) ? 0 : 50);
    end
    load_dense_bias();
    compute_expected();
    run_inference();
    check_results("tie");
    checks++;
    if (int'(pred_index) != 1) report_mismatch("tie pred_index", int'(pred_index), 1);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n   = 1'b0;
    wr_en   = 1'b0;
    wr_sel  = cnn_pkg::SEL_IMG;
    wr_addr = '0;
    wr_data = '0;
    start   = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_reset_values();
    test_hand_case();
    test_random();
    test_bad_writes();
    test_new_image();
    test_tie_break();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== test/tb_cnn_asserts.sv ====
`timescale 1ns/1ps

module tb_cnn_asserts #(
  parameter int CLASSES = 4
) (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               start,
  input logic                               done,
  input logic [$clog2(CLASSES)-1:0]         pred_index,
  input logic [CLASSES*cnn_pkg::DATA_W-1:0] logits,
  input cnn_pkg::infer_state_t              ctrl_state
);

  // a start taken in idle clears done on the next cycle
  a_done_drops: assert property (
    @(posedge clk) disable iff (!rst_n)
    (start && ctrl_state == cnn_pkg::ST_IDLE) |=> !done
  ) else $error("done stayed high after start was accepted in idle");

  // results hold while done is up and nothing new is started
  a_result_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (done && !start) |=> ($stable(logits) && $stable(pred_index))
  ) else $error("logits or pred_index changed while done was high");

  a_pred_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    int'(pred_index) < CLASSES
  ) else $error("pred_index out of range");

endmodule

bind cnn_top tb_cnn_asserts #(.CLASSES(CLASSES)) u_asserts (
  .clk(clk), .rst_n(rst_n), .start(start), .done(done),
  .pred_index(pred_index), .logits(logits), .ctrl_state(u_ctrl.state)
);

// ==== verilog.f ====
design/cnn_pkg.sv
design/weight_store.sv
design/conv_stage.sv
design/pool_avg_stage.sv
design/dense_stage.sv
design/infer_ctrl.sv
design/cnn_top.sv
test/tb_cnn_asserts.sv
test/tb_cnn.sv
